// ==== hdl/isaPkg.sv ====
package isaPkg;

   // alu operation select, order follows the processor's funct encoding
   typedef enum logic [2:0] {
      aluRol  = 3'b000,
      aluSll  = 3'b001,
      aluSra  = 3'b010,
      aluSrl  = 3'b011,
      aluAdd  = 3'b100,
      // inB minus inA, operand order of the family's sub instructions
      aluSub  = 3'b101,
      aluXor  = 3'b110,
      // inA and not inB
      aluAndn = 3'b111
   } aluOpT;

   // set-compare select, setNone lets the alu result through
   typedef enum logic [2:0] {
      setNone  = 3'b000,
      setEq    = 3'b001,
      setLt    = 3'b010,
      setLe    = 3'b011,
      setCarry = 3'b100
   } setOpT;

   // branch condition, tested on the first register operand
   typedef enum logic [2:0] {
      brNone = 3'b000,
      brEqz  = 3'b001,
      brNez  = 3'b010,
      brLtz  = 3'b011,
      brGez  = 3'b100
   } branchOpT;

   // jump kind
   // jmpRel goes to incPc plus immediate, jmpReg to the alu sum
   typedef enum logic [1:0] {
      jmpNone = 2'b00,
      jmpRel  = 2'b01,
      jmpReg  = 2'b10
   } jumpOpT;

endpackage

// ==== hdl/dataPkg.sv ====
package dataPkg;

   // machine word width, default for the whole datapath
   localparam int wordWidth = 16;

   // bits per carry-lookahead group
   // carries are looked ahead inside a group and ripple between groups
   localparam int claGroup = 4;

endpackage

// ==== hdl/claAdder.sv ====
`timescale 1ns/1ps

module claAdder #(
   parameter int dataWidth = 16
) (
   input  logic [dataWidth-1:0] a,
   input  logic [dataWidth-1:0] b,
   input  logic                 cIn,
   output logic [dataWidth-1:0] sum,
   output logic                 cOut
);

   localparam int groupSize   = dataPkg::claGroup;
   localparam int numGroups   = (dataWidth + groupSize - 1) / groupSize;
   // operands are zero padded up to a whole number of groups
   localparam int paddedWidth = numGroups * groupSize;

   logic [paddedWidth-1:0] aPad;
   logic [paddedWidth-1:0] bPad;
   logic [paddedWidth-1:0] gen;
   logic [paddedWidth-1:0] prop;
   // carry[i] is the carry into bit i
   logic [paddedWidth:0]   carry;

   // lookahead carries of one group from its generate, propagate and carry-in
   function automatic logic [groupSize:0] groupCarries(
      input logic [groupSize-1:0] g,
      input logic [groupSize-1:0] p,
      input logic                 c0
   );
      logic [groupSize:0] c;
      logic               chain;
      logic               accum;
      c[0] = c0;
      for (int k = 1; k <= groupSize; k++) begin
         chain = 1'b1;
         accum = 1'b0;
         // sum of products g[m] and p[m+1..k-1], then the carry-in term
         for (int m = k - 1; m >= 0; m--) begin
            accum = accum | (chain & g[m]);
            chain = chain & p[m];
         end
         c[k] = accum | (chain & c0);
      end
      return c;
   endfunction

   assign aPad = paddedWidth'(a);
   assign bPad = paddedWidth'(b);

   // per-bit generate and propagate
   assign gen  = aPad & bPad;
   assign prop = aPad ^ bPad;

   assign carry[0] = cIn;

   for (genvar grp = 0; grp < numGroups; grp++) begin : gGroup
      logic [groupSize:0] groupC;
      assign groupC = groupCarries(gen[grp*groupSize +: groupSize],
                                   prop[grp*groupSize +: groupSize],
                                   carry[grp*groupSize]);
      // group carry-out feeds the next group
      assign carry[grp*groupSize+1 +: groupSize] = groupC[groupSize:1];
   end

   assign sum  = prop[dataWidth-1:0] ^ carry[dataWidth-1:0];
   // padding bits neither generate nor propagate
   assign cOut = carry[dataWidth];

endmodule

// ==== hdl/alu.sv ====
`timescale 1ns/1ps

module alu #(
   parameter int dataWidth = 16
) (
   input  logic [dataWidth-1:0] inA,
   input  logic [dataWidth-1:0] inB,
   input  isaPkg::aluOpT        op,
   output logic [dataWidth-1:0] out,
   output logic                 zero,
   output logic                 ofl,
   output logic                 carry
);

   // shift amount width, four bits for a 16-bit word
   localparam int shiftBits = $clog2(dataWidth);

   logic [shiftBits-1:0] amount;
   logic [dataWidth-1:0] shiftVal;
   logic [dataWidth-1:0] addA;
   logic [dataWidth-1:0] addSum;
   logic                 isSub;
   logic                 isArith;

   assign amount = inB[shiftBits-1:0];

   // logarithmic shifter
   // stage s moves by 2**s when amount bit s is set
   always_comb begin
      shiftVal = inA;
      for (int s = 0; s < shiftBits; s++) begin
         if (amount[s]) begin
            unique case (op)
               isaPkg::aluRol:
                  shiftVal = (shiftVal << (1 << s)) | (shiftVal >> (dataWidth - (1 << s)));
               isaPkg::aluSll:
                  shiftVal = shiftVal << (1 << s);
               isaPkg::aluSra:
                  shiftVal = $signed(shiftVal) >>> (1 << s);
               // srl, the non-shift ops ignore this value
               default:
                  shiftVal = shiftVal >> (1 << s);
            endcase
         end
      end
   end

   assign isSub   = (op == isaPkg::aluSub);
   assign isArith = (op == isaPkg::aluAdd) || isSub;

   // subtract is inB + ~inA + 1
   assign addA = isSub ? ~inA : inA;

   // one adder shared by add and subtract
   claAdder #(
      .dataWidth(dataWidth)
   ) adder0 (
      .a   (addA),
      .b   (inB),
      .cIn (isSub),
      .sum (addSum),
      .cOut(carry)
   );

   always_comb begin
      unique case (op)
         isaPkg::aluRol,
         isaPkg::aluSll,
         isaPkg::aluSra,
         isaPkg::aluSrl:  out = shiftVal;
         isaPkg::aluAdd,
         isaPkg::aluSub:  out = addSum;
         isaPkg::aluXor:  out = inA ^ inB;
         isaPkg::aluAndn: out = inA & ~inB;
         default:         out = '0;
      endcase
   end

   assign zero = (out == '0);

   // signed overflow, both adder operands agree in sign and the sum does not
   // carry is only meaningful as inA + inB, i.e. any op but aluSub
   assign ofl = isArith &&
                (addA[dataWidth-1] == inB[dataWidth-1]) &&
                (addSum[dataWidth-1] != inB[dataWidth-1]);

endmodule

// ==== hdl/branchControl.sv ====
`timescale 1ns/1ps

module branchControl #(
   parameter int dataWidth = 16
) (
   input  logic [dataWidth-1:0] regData1,
   input  isaPkg::branchOpT     branchOp,
   output logic                 branch
);

   logic isZero;
   logic isNeg;

   assign isZero = (regData1 == '0);
   // sign bit of the tested register
   assign isNeg  = regData1[dataWidth-1];

   // taken decision per condition
   always_comb begin
      unique case (branchOp)
         isaPkg::brEqz: branch = isZero;
         isaPkg::brNez: branch = !isZero;
         isaPkg::brLtz: branch = isNeg;
         isaPkg::brGez: branch = !isNeg;
         // brNone and unused codes never branch
         default:       branch = 1'b0;
      endcase
   end

endmodule

// ==== hdl/execute.sv ====
`timescale 1ns/1ps

module execute #(
   parameter int dataWidth = 16
) (
   input  isaPkg::aluOpT        aluOp,
   input  isaPkg::setOpT        setOp,
   input  isaPkg::branchOpT     branchOp,
   input  isaPkg::jumpOpT       jumpOp,
   input  logic                 aluSrc,
   input  logic                 lbi,
   input  logic                 slbi,
   input  logic                 btr,
   input  logic                 ror,
   input  logic [dataWidth-1:0] regData1,
   input  logic [dataWidth-1:0] regData2,
   input  logic [dataWidth-1:0] immVal,
   input  logic [dataWidth-1:0] incPc,
   output logic [dataWidth-1:0] result,
   output logic                 zero,
   output logic                 ofl,
   output logic [dataWidth-1:0] newPc,
   output logic                 pcSrc
);

   logic [dataWidth-1:0] inA;
   logic [dataWidth-1:0] regB;
   logic [dataWidth-1:0] rorB;
   logic [dataWidth-1:0] inB;
   logic [dataWidth-1:0] aluOut;
   logic                 carry;
   logic [dataWidth-1:0] diff;
   logic                 diffOfl;
   logic                 setEq;
   logic                 setLt;
   logic                 setBit;
   logic [dataWidth-1:0] revA;
   logic [dataWidth-1:0] pcTarget;
   logic                 branch;

   // slbi shifts the register up by a byte before the alu ors in the immediate
   assign inA  = slbi ? (regData1 << 8) : regData1;
   assign regB = aluSrc ? immVal : regData2;

   // word width minus inB, so rotate-left by that amount rotates right
   claAdder #(
      .dataWidth(dataWidth)
   ) rorAdder (
      .a   (dataWidth'(dataWidth)),
      .b   (~regB),
      .cIn (1'b1),
      .sum (rorB),
      .cOut()
   );

   assign inB = ror ? rorB : regB;

   alu #(
      .dataWidth(dataWidth)
   ) alu0 (
      .inA  (inA),
      .inB  (inB),
      .op   (aluOp),
      .out  (aluOut),
      .zero (zero),
      .ofl  (ofl),
      .carry(carry)
   );

   // inA minus inB for the signed compares
   claAdder #(
      .dataWidth(dataWidth)
   ) setAdder (
      .a   (inA),
      .b   (~inB),
      .cIn (1'b1),
      .sum (diff),
      .cOut()
   );

   // overflow of the difference flips the sign of the answer
   assign diffOfl = (inA[dataWidth-1] != inB[dataWidth-1]) &&
                    (diff[dataWidth-1] != inA[dataWidth-1]);
   assign setEq   = (diff == '0);
   assign setLt   = diff[dataWidth-1] ^ diffOfl;

   // set carry takes the alu adder, which sums inA + inB unless the op is aluSub
   always_comb begin
      unique case (setOp)
         isaPkg::setEq:    setBit = setEq;
         isaPkg::setLt:    setBit = setLt;
         isaPkg::setLe:    setBit = setLt | setEq;
         isaPkg::setCarry: setBit = carry;
         default:          setBit = 1'b0;
      endcase
   end

   // btr mirrors the word end for end
   always_comb begin
      for (int i = 0; i < dataWidth; i++) begin
         revA[i] = inA[dataWidth-1-i];
      end
   end

   // result select, lbi first, then set, then btr
   always_comb begin
      if (lbi) begin
         result = immVal;
      end else if (setOp != isaPkg::setNone) begin
         result = {{(dataWidth-1){1'b0}}, setBit};
      end else if (btr) begin
         result = revA;
      end else begin
         result = aluOut;
      end
   end

   // branch and relative jump target
   claAdder #(
      .dataWidth(dataWidth)
   ) pcAdder (
      .a   (incPc),
      .b   (immVal),
      .cIn (1'b0),
      .sum (pcTarget),
      .cOut()
   );

   branchControl #(
      .dataWidth(dataWidth)
   ) branch0 (
      .regData1(regData1),
      .branchOp(branchOp),
      .branch  (branch)
   );

   assign pcSrc = branch || (jumpOp != isaPkg::jmpNone);
   // register jumps take register plus immediate from the alu
   assign newPc = (jumpOp == isaPkg::jmpReg) ? aluOut : pcTarget;

endmodule

// ==== hdl/exMemRegister.sv ====
`timescale 1ns/1ps

module exMemRegister #(
   parameter int dataWidth = 16
) (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 inValid,
   input  logic [dataWidth-1:0] result,
   input  logic                 zero,
   input  logic                 ofl,
   input  logic [dataWidth-1:0] newPc,
   input  logic                 pcSrc,
   output logic                 outValid,
   output logic [dataWidth-1:0] outResult,
   output logic                 outZero,
   output logic                 outOfl,
   output logic [dataWidth-1:0] outNewPc,
   output logic                 outPcSrc
);

   // control bits, cleared on reset and on an idle cycle
   always_ff @(posedge clk) begin
      if (reset) begin
         outValid <= 1'b0;
         outPcSrc <= 1'b0;
      end else begin
         outValid <= inValid;
         // a redirect only leaves with a valid item
         outPcSrc <= inValid & pcSrc;
      end
   end

   // payload, loaded on valid cycles and held otherwise
   always_ff @(posedge clk) begin
      if (inValid) begin
         outResult <= result;
         outZero   <= zero;
         outOfl    <= ofl;
         outNewPc  <= newPc;
      end
   end

endmodule

// ==== hdl/executeStage.sv ====
`timescale 1ns/1ps

module executeStage #(
   parameter int dataWidth = dataPkg::wordWidth
) (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 inValid,
   input  isaPkg::aluOpT        aluOp,
   input  isaPkg::setOpT        setOp,
   input  isaPkg::branchOpT     branchOp,
   input  isaPkg::jumpOpT       jumpOp,
   input  logic                 aluSrc,
   input  logic                 lbi,
   input  logic                 slbi,
   input  logic                 btr,
   input  logic                 ror,
   input  logic [dataWidth-1:0] regData1,
   input  logic [dataWidth-1:0] regData2,
   input  logic [dataWidth-1:0] immVal,
   input  logic [dataWidth-1:0] incPc,
   output logic                 outValid,
   output logic [dataWidth-1:0] outResult,
   output logic                 outZero,
   output logic                 outOfl,
   output logic [dataWidth-1:0] outNewPc,
   output logic                 outPcSrc
);

   // combinational execute results, before the pipeline register
   logic [dataWidth-1:0] exResult;
   logic                 exZero;
   logic                 exOfl;
   logic [dataWidth-1:0] exNewPc;
   logic                 exPcSrc;

   execute #(
      .dataWidth(dataWidth)
   ) execute0 (
      .aluOp   (aluOp),
      .setOp   (setOp),
      .branchOp(branchOp),
      .jumpOp  (jumpOp),
      .aluSrc  (aluSrc),
      .lbi     (lbi),
      .slbi    (slbi),
      .btr     (btr),
      .ror     (ror),
      .regData1(regData1),
      .regData2(regData2),
      .immVal  (immVal),
      .incPc   (incPc),
      .result  (exResult),
      .zero    (exZero),
      .ofl     (exOfl),
      .newPc   (exNewPc),
      .pcSrc   (exPcSrc)
   );

   // one cycle to the memory stage
   exMemRegister #(
      .dataWidth(dataWidth)
   ) exMem0 (
      .clk      (clk),
      .reset    (reset),
      .inValid  (inValid),
      .result   (exResult),
      .zero     (exZero),
      .ofl      (exOfl),
      .newPc    (exNewPc),
      .pcSrc    (exPcSrc),
      .outValid (outValid),
      .outResult(outResult),
      .outZero  (outZero),
      .outOfl   (outOfl),
      .outNewPc (outNewPc),
      .outPcSrc (outPcSrc)
   );

endmodule

// ==== tb/executeStage_checker.sv ====
`timescale 1ns/1ps

module executeStage_checker (
   input logic clk,
   input logic reset,
   input logic inValid,
   input logic outValid,
   input logic outPcSrc
);

   // one cycle from a sampled inValid to outValid
   // skipped on the edge right after a reset cycle
   property validFollows;
      @(posedge clk) disable iff (reset)
         !$past(reset) |-> (outValid == $past(inValid));
   endproperty

   // a redirect never leaves without a valid item
   property pcSrcNeedsValid;
      @(posedge clk) outPcSrc |-> outValid;
   endproperty

   // first edge after reset drops, both control bits still clear
   property clearAfterReset;
      @(posedge clk) ($past(reset) && !reset) |-> (!outValid && !outPcSrc);
   endproperty

   validFollowsA: assert property (validFollows)
      else $error("outValid does not follow inValid by one cycle");

   pcSrcNeedsValidA: assert property (pcSrcNeedsValid)
      else $error("outPcSrc high without outValid");

   clearAfterResetA: assert property (clearAfterReset)
      else $error("outValid or outPcSrc set in the cycle after reset");

endmodule

// ==== tb/executeStage_tb.sv ====
`timescale 1ns/1ps

module executeStage_tb;

   localparam int dw = dataPkg::wordWidth;
   localparam int shiftBits = $clog2(dw);
   // reset, stimulus and margin, in clock cycles
   localparam int cycleLimit = 16 + 800 + 200;

   // one item as the decode stage hands it over
   typedef struct packed {
      isaPkg::aluOpT    aluOp;
      isaPkg::setOpT    setOp;
      isaPkg::branchOpT branchOp;
      isaPkg::jumpOpT   jumpOp;
      logic             aluSrc;
      logic             lbi;
      logic             slbi;
      logic             btr;
      logic             ror;
      logic [dw-1:0]    r1;
      logic [dw-1:0]    r2;
      logic [dw-1:0]    imm;
      logic [dw-1:0]    incPc;
   } stimT;

   // what the memory stage should see one cycle later
   typedef struct packed {
      logic [dw-1:0] result;
      logic          zero;
      logic          ofl;
      logic [dw-1:0] newPc;
      logic          pcSrc;
   } expT;

   logic             clk;
   logic             reset;
   logic             inValid;
   isaPkg::aluOpT    aluOp;
   isaPkg::setOpT    setOp;
   isaPkg::branchOpT branchOp;
   isaPkg::jumpOpT   jumpOp;
   logic             aluSrc;
   logic             lbi;
   logic             slbi;
   logic             btr;
   logic             ror;
   logic [dw-1:0]    regData1;
   logic [dw-1:0]    regData2;
   logic [dw-1:0]    immVal;
   logic [dw-1:0]    incPc;
   logic             outValid;
   logic [dw-1:0]    outResult;
   logic             outZero;
   logic             outOfl;
   logic [dw-1:0]    outNewPc;
   logic             outPcSrc;

   expT  expQ[$];
   logic expValid;
   int   seed = 32'ha423_a5e3;
   int   cycleCount = 0;
   int   errors = 0;
   int   checks = 0;
   int   testStart = 0;

   // edge operands for the alu and the set compares
   logic [dw-1:0] edgeA [0:5] = '{16'h0000, 16'h7fff, 16'h8000, 16'hffff, 16'h8000, 16'h1234};
   logic [dw-1:0] edgeB [0:5] = '{16'h0000, 16'h0001, 16'hffff, 16'hffff, 16'h8000, 16'h000f};
   logic [dw-1:0] setA [0:7] = '{16'h0005, 16'hffff, 16'h0001, 16'h8000,
                                  16'h7fff, 16'h8000, 16'h7fff, 16'h0000};
   logic [dw-1:0] setB [0:7] = '{16'h0005, 16'h0001, 16'hffff, 16'h7fff,
                                  16'h8000, 16'h8000, 16'h7fff, 16'h8000};

   executeStage #(
      .dataWidth(dw)
   ) dut0 (
      .clk      (clk),
      .reset    (reset),
      .inValid  (inValid),
      .aluOp    (aluOp),
      .setOp    (setOp),
      .branchOp (branchOp),
      .jumpOp   (jumpOp),
      .aluSrc   (aluSrc),
      .lbi      (lbi),
      .slbi     (slbi),
      .btr      (btr),
      .ror      (ror),
      .regData1 (regData1),
      .regData2 (regData2),
      .immVal   (immVal),
      .incPc    (incPc),
      .outValid (outValid),
      .outResult(outResult),
      .outZero  (outZero),
      .outOfl   (outOfl),
      .outNewPc (outNewPc),
      .outPcSrc (outPcSrc)
   );

   bind exMemRegister executeStage_checker chk0 (
      .clk     (clk),
      .reset   (reset),
      .inValid (inValid),
      .outValid(outValid),
      .outPcSrc(outPcSrc)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   always @(posedge clk) begin
      cycleCount <= cycleCount + 1;
   end

   // expected outputs straight from the instruction rules
   function automatic expT refExecute(input stimT s);
      logic [dw-1:0]        a;
      logic [dw-1:0]        rb;
      logic [dw-1:0]        b;
      logic [dw-1:0]        aluOut;
      logic [dw-1:0]        rev;
      logic [dw:0]          wide;
      logic [shiftBits-1:0] amt;
      logic                 carry;
      logic                 setBit;
      logic                 branch;
      int                   sa;
      int                   sb;
      int                   sum;
      expT                  e;
      a = s.slbi ? (s.r1 << 8) : s.r1;
      rb = s.aluSrc ? s.imm : s.r2;
      // ror turns the rotate amount into word width minus inB
      b = s.ror ? dw - rb : rb;
      amt = b[shiftBits-1:0];
      sa = $signed(a);
      sb = $signed(b);
      e.ofl = 1'b0;
      case (s.aluOp)
         isaPkg::aluRol:  aluOut = (a << amt) | (a >> (dw - amt));
         isaPkg::aluSll:  aluOut = a << amt;
         isaPkg::aluSra:  aluOut = $signed(a) >>> amt;
         isaPkg::aluSrl:  aluOut = a >> amt;
         isaPkg::aluAdd:  aluOut = a + b;
         // reversed operand order, inB minus inA
         isaPkg::aluSub:  aluOut = b - a;
         isaPkg::aluXor:  aluOut = a ^ b;
         default:         aluOut = a & ~b;
      endcase
      if (s.aluOp == isaPkg::aluAdd || s.aluOp == isaPkg::aluSub) begin
         sum = (s.aluOp == isaPkg::aluAdd) ? sa + sb : sb - sa;
         e.ofl = (sum > 2 ** (dw - 1) - 1) || (sum < -(2 ** (dw - 1)));
      end
      e.zero = (aluOut == '0);
      wide = {1'b0, a} + {1'b0, b};
      // subtract carry means no borrow
      carry = (s.aluOp == isaPkg::aluSub) ? (b >= a) : wide[dw];
      case (s.setOp)
         isaPkg::setEq:    setBit = (a == b);
         isaPkg::setLt:    setBit = (sa < sb);
         isaPkg::setLe:    setBit = (sa <= sb);
         isaPkg::setCarry: setBit = carry;
         default:          setBit = 1'b0;
      endcase
      for (int i = 0; i < dw; i++) begin
         rev[i] = a[dw-1-i];
      end
      if (s.lbi) begin
         e.result = s.imm;
      end else if (s.setOp != isaPkg::setNone) begin
         e.result = dw'(setBit);
      end else if (s.btr) begin
         e.result = rev;
      end else begin
         e.result = aluOut;
      end
      case (s.branchOp)
         isaPkg::brEqz: branch = (s.r1 == '0);
         isaPkg::brNez: branch = (s.r1 != '0);
         isaPkg::brLtz: branch = s.r1[dw-1];
         isaPkg::brGez: branch = !s.r1[dw-1];
         default:       branch = 1'b0;
      endcase
      e.pcSrc = branch || (s.jumpOp != isaPkg::jmpNone);
      e.newPc = (s.jumpOp == isaPkg::jmpReg) ? aluOut : s.incPc + s.imm;
      return e;
   endfunction

   function automatic logic [dw-1:0] randWord();
      return $random(seed);
   endfunction

   // plain alu item, no strobes, no set, no branch
   function automatic stimT plainStim(input isaPkg::aluOpT op, input logic [dw-1:0] r1,
                                      input logic [dw-1:0] r2);
      stimT s;
      s = '0;
      s.aluOp = op;
      s.r1 = r1;
      s.r2 = r2;
      s.imm = randWord();
      s.incPc = randWord();
      return s;
   endfunction

   // every field random, enum codes kept in range
   function automatic stimT fullRandomStim();
      stimT          s;
      logic [dw-1:0] r;
      r = randWord();
      s = plainStim(isaPkg::aluOpT'(r[2:0]), randWord(), randWord());
      s.setOp = isaPkg::setOpT'(3'(r[5:3] % 5));
      s.branchOp = isaPkg::branchOpT'(3'(r[8:6] % 5));
      s.jumpOp = isaPkg::jumpOpT'(2'(r[10:9] % 3));
      s.aluSrc = r[11];
      s.slbi = r[12];
      s.ror = r[13];
      s.btr = r[14];
      s.lbi = (r[15] && r[0]);
      return s;
   endfunction

   // one valid cycle, the expected item is queued when tracked
   task automatic driveItem(input stimT s, input bit track);
      @(posedge clk);
      inValid  <= 1'b1;
      aluOp    <= s.aluOp;
      setOp    <= s.setOp;
      branchOp <= s.branchOp;
      jumpOp   <= s.jumpOp;
      aluSrc   <= s.aluSrc;
      lbi      <= s.lbi;
      slbi     <= s.slbi;
      btr      <= s.btr;
      ror      <= s.ror;
      regData1 <= s.r1;
      regData2 <= s.r2;
      immVal   <= s.imm;
      incPc    <= s.incPc;
      if (track) begin
         expQ.push_back(refExecute(s));
      end
   endtask

   task automatic idle(input int n);
      repeat (n) begin
         @(posedge clk);
         inValid <= 1'b0;
      end
   endtask

   // let the pipe empty, then report the test
   task automatic endTest(input string name);
      idle(3);
      if (expQ.size() != 0) begin
         $display("error: %0d expected items never came out in test %s", expQ.size(), name);
         errors++;
         expQ.delete();
      end
      $display("test %s finished with %0d errors", name, errors - testStart);
      testStart = errors;
   endtask

   task automatic compareField(input string name, input logic [dw-1:0] got,
                               input logic [dw-1:0] exp);
      checks++;
      assert (got === exp) else begin
         $display("Fail at %0t: %s is %h, expected %h", $time, name, got, exp);
         errors++;
      end
   endtask

   // compare at the falling edge, outputs settled by then
   initial begin
      expT e;
      expValid = 1'b0;
      forever begin
         @(negedge clk);
         checks++;
         assert (outValid === expValid) else begin
            $display("Fail at %0t: outValid is %b, expected %b", $time, outValid, expValid);
            errors++;
         end
         assert (outValid === 1'b1 || outPcSrc === 1'b0) else begin
            $display("Fail at %0t: outPcSrc is %b on an idle cycle", $time, outPcSrc);
            errors++;
         end
         if (outValid === 1'b1) begin
            if (expQ.size() == 0) begin
               $display("error at %0t: output valid arrived with nothing expected", $time);
               errors++;
            end else begin
               e = expQ.pop_front();
               compareField("result", outResult, e.result);
               compareField("zero", dw'(outZero), dw'(e.zero));
               compareField("ofl", dw'(outOfl), dw'(e.ofl));
               compareField("newPc", outNewPc, e.newPc);
               compareField("pcSrc", dw'(outPcSrc), dw'(e.pcSrc));
            end
         end
         // what the next edge captures
         expValid = inValid && !reset;
      end
   end

   initial begin
      while (cycleCount < cycleLimit) begin
         @(posedge clk);
      end
      $display("timeout: run stopped after %0d cycles", cycleCount);
      $display("*** FAILED ***");
      $finish;
   end

   initial begin
      stimT s;
      int   gap;
      reset    = 1'b1;
      inValid  = 1'b0;
      aluOp    = isaPkg::aluAdd;
      setOp    = isaPkg::setNone;
      branchOp = isaPkg::brNone;
      jumpOp   = isaPkg::jmpNone;
      aluSrc   = 1'b0;
      lbi      = 1'b0;
      slbi     = 1'b0;
      btr      = 1'b0;
      ror      = 1'b0;
      regData1 = '0;
      regData2 = '0;
      immVal   = '0;
      incPc    = '0;
      repeat (16) @(posedge clk);
      reset <= 1'b0;

      // every alu op on edge values, then random ones
      for (int op = 0; op < 8; op++) begin
         for (int i = 0; i < 6; i++) begin
            driveItem(plainStim(isaPkg::aluOpT'(op), edgeA[i], edgeB[i]), 1'b1);
         end
         for (int i = 0; i < 20; i++) begin
            driveItem(plainStim(isaPkg::aluOpT'(op), randWord(), randWord()), 1'b1);
         end
      end
      endTest("alu operations");

      // immediate select, slbi, ror, btr and lbi
      for (int i = 0; i < 10; i++) begin
         s = plainStim(isaPkg::aluAdd, randWord(), randWord());
         s.aluSrc = 1'b1;
         driveItem(s, 1'b1);
         s = plainStim(isaPkg::aluXor, randWord(), randWord());
         s.slbi = 1'b1;
         s.aluSrc = 1'b1;
         driveItem(s, 1'b1);
         s = plainStim(isaPkg::aluRol, randWord(), randWord());
         s.ror = 1'b1;
         s.aluSrc = i[0];
         driveItem(s, 1'b1);
         s = plainStim(isaPkg::aluAdd, randWord(), randWord());
         s.btr = 1'b1;
         driveItem(s, 1'b1);
         s = plainStim(isaPkg::aluSub, randWord(), randWord());
         s.lbi = 1'b1;
         driveItem(s, 1'b1);
      end
      endTest("operand shaping");

      // equal, sign-crossing and extreme operands
      for (int so = 1; so < 5; so++) begin
         for (int i = 0; i < 8; i++) begin
            s = plainStim(isaPkg::aluAdd, setA[i], setB[i]);
            s.setOp = isaPkg::setOpT'(so);
            driveItem(s, 1'b1);
         end
         for (int i = 0; i < 8; i++) begin
            s = plainStim(isaPkg::aluOpT'(i), randWord(), randWord());
            s.setOp = isaPkg::setOpT'(so);
            driveItem(s, 1'b1);
         end
      end
      endTest("set compares");

      // zero, positive and negative register for each condition
      for (int br = 0; br < 5; br++) begin
         for (int v = 0; v < 3; v++) begin
            s = plainStim(isaPkg::aluAdd, (v == 0) ? 16'h0000 : (v == 1) ? 16'h1234 : 16'h8001,
                          randWord());
            s.branchOp = isaPkg::branchOpT'(br);
            driveItem(s, 1'b1);
         end
      end
      for (int j = 1; j < 3; j++) begin
         for (int i = 0; i < 5; i++) begin
            s = plainStim(isaPkg::aluAdd, randWord(), randWord());
            s.jumpOp = isaPkg::jumpOpT'(j);
            s.aluSrc = 1'b1;
            driveItem(s, 1'b1);
         end
      end
      endTest("branches and jumps");

      // random gaps between items
      for (int i = 0; i < 20; i++) begin
         driveItem(fullRandomStim(), 1'b1);
         gap = randWord() % 3;
         idle(gap);
      end
      // a jump caught by reset must never leave the register
      s = plainStim(isaPkg::aluAdd, randWord(), randWord());
      s.jumpOp = isaPkg::jmpRel;
      driveItem(s, 1'b0);
      reset <= 1'b1;
      idle(4);
      reset <= 1'b0;
      for (int i = 0; i < 10; i++) begin
         driveItem(fullRandomStim(), 1'b1);
      end
      endTest("pipeline timing");

      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

endmodule

// ==== all.f ====
hdl/isaPkg.sv
hdl/dataPkg.sv
hdl/claAdder.sv
hdl/alu.sv
hdl/branchControl.sv
hdl/execute.sv
hdl/exMemRegister.sv
hdl/executeStage.sv
tb/executeStage_checker.sv
tb/executeStage_tb.sv
